// ==== verilog/ub_config.svh ====
`ifndef UB_CONFIG_SVH
`define UB_CONFIG_SVH

// buffer geometry, 8 rows of 8 words
`define UB_ROWS 8
`define UB_COLS 8

`define UB_DATA_W 16 // word width

// index widths
`define UB_ROW_W 3
`define UB_COL_W 3

// word address is {row, col}
`define UB_ADDR_W 6

`endif

// ==== verilog/ub_pkg.sv ====
`default_nettype none

`include "ub_config.svh"

package ub_pkg;

    typedef logic [`UB_DATA_W-1:0] ub_word_t;

    // one accumulator row, column 0 in the lowest slice
    typedef ub_word_t [`UB_COLS-1:0] act_row_t;

    // wishbone classic master request
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`UB_ADDR_W-1:0] adr;
        logic [`UB_DATA_W-1:0] dat;
    } wb_req_t;

    // single word write into one bank
    typedef struct packed {
        logic                 en;
        logic [`UB_COL_W-1:0] col;
        ub_word_t             data;
    } bank_wr_t;

    typedef struct packed {
        ub_word_t data;
        logic     last; // set on the final word
    } stream_beat_t;

    typedef enum logic {
        S_IDLE,
        S_RUN
    } stream_state_t;

endpackage

`default_nettype wire

// ==== verilog/ub_dma_port.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "ub_config.svh"

module ub_dma_port (
    input  wire                      clk,
    input  wire                      reset,
    input  wire ub_pkg::wb_req_t     wb_req,
    input  wire                      store,
    output logic                     wb_ack,
    output ub_pkg::bank_wr_t         dma_wr,
    output logic [`UB_ROWS-1:0]      dma_row_sel
);

    logic                 take;
    logic [`UB_ROW_W-1:0] row;

    // a request is taken once, and never while a row store is in progress
    assign take = wb_req.cyc && wb_req.stb && !wb_ack && !store;

    assign row = wb_req.adr[`UB_ADDR_W-1:`UB_COL_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= take; // one cycle pulse
        end
    end

    // the bank write lands on the same edge that raises ack
    always_comb begin
        dma_wr.en   = take && wb_req.we; // reads are acked but write nothing
        dma_wr.col  = wb_req.adr[`UB_COL_W-1:0];
        dma_wr.data = wb_req.dat;
    end

    assign dma_row_sel = `UB_ROWS'(1) << row;

    // host drops stb after ack, so a second ack right behind would be a double write
    ack_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack
    ) else $error("wb_ack held for more than one cycle");

endmodule

`default_nettype wire

// ==== verilog/ub_row_bank.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "ub_config.svh"

module ub_row_bank (
    input  wire                     clk,
    input  wire                     reset,
    input  wire ub_pkg::bank_wr_t   dma_wr,
    input  wire                     dma_sel,
    input  wire                     row_store,
    input  wire ub_pkg::act_row_t   row_in,
    input  wire [`UB_COL_W-1:0]     rd_col,
    output ub_pkg::ub_word_t        rd_data
);

    import ub_pkg::*;

    ub_word_t words [`UB_COLS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `UB_COLS; i++) begin
                words[i] <= '0;
            end
        end else if (row_store) begin
            // whole accumulator row at once
            for (int i = 0; i < `UB_COLS; i++) begin
                words[i] <= row_in[i];
            end
        end else if (dma_sel && dma_wr.en) begin
            words[dma_wr.col] <= dma_wr.data;
        end
    end

    assign rd_data = words[rd_col]; // async read for the stream sequencer

    // the dma port holds off its write while store is high
    no_store_dma_clash: assert property (
        @(posedge clk) disable iff (reset)
        !(dma_sel && dma_wr.en && row_store)
    ) else $error("dma write and row store hit the same bank together");

endmodule

`default_nettype wire

// ==== verilog/ub_stream_out.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "ub_config.svh"

module ub_stream_out (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      ext_start,
    input  wire ub_pkg::ub_word_t    bank_data [`UB_ROWS],
    input  wire                      out_ready,
    output logic [`UB_COL_W-1:0]     rd_col,
    output ub_pkg::stream_beat_t     out_beat,
    output logic                     out_valid
);

    import ub_pkg::*;

    localparam int LAST_ADDR = `UB_ROWS * `UB_COLS - 1;

    stream_state_t         state;
    logic [`UB_ADDR_W-1:0] ptr;  // address of the next word to fetch
    logic [`UB_ROW_W-1:0]  rd_row;
    logic                  accept;
    logic                  load;

    assign rd_row    = ptr[`UB_ADDR_W-1:`UB_COL_W];
    assign rd_col    = ptr[`UB_COL_W-1:0];
    assign out_valid = (state == S_RUN);
    assign accept    = out_valid && out_ready;

    // fetch on start, then each time a beat other than the last is taken
    assign load = (state == S_IDLE) ? ext_start : (accept && !out_beat.last);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            ptr   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (ext_start) state <= S_RUN;
                end
                S_RUN: begin
                    // start pulses are ignored here
                    if (accept && out_beat.last) state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
            if (load) ptr <= ptr + 1'b1; // wraps back to 0 after word 63
        end
    end

    // registered beat, so a stall holds it even if the memory changes
    always_ff @(posedge clk) begin
        if (load) begin
            out_beat.data <= bank_data[rd_row];
            out_beat.last <= (ptr == `UB_ADDR_W'(LAST_ADDR));
        end
    end

    beat_held_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_beat)
    ) else $error("stream beat changed while stalled");

endmodule

`default_nettype wire

// ==== verilog/unified_buffer.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "ub_config.svh"

module unified_buffer (
    input  wire                        clk,
    input  wire                        reset,

    // host dma port, wishbone classic, write only
    input  wire ub_pkg::wb_req_t       wb_req,
    output wire                        wb_ack,

    // bulk row store from the accumulators
    input  wire                        store,
    input  wire [`UB_ROWS-1:0]         acc_full,
    input  wire ub_pkg::act_row_t      acc_rows [`UB_ROWS],

    // sequential readout
    input  wire                        ext_start,
    output wire ub_pkg::stream_beat_t  out_beat,
    output wire                        out_valid,
    input  wire                        out_ready
);

    import ub_pkg::*;

    wire bank_wr_t             dma_wr;
    wire [`UB_ROWS-1:0]        dma_row_sel;
    wire [`UB_COL_W-1:0]       rd_col;
    wire ub_word_t             bank_data [`UB_ROWS];

    ub_dma_port u_dma_port (
        .clk         (clk),
        .reset       (reset),
        .wb_req      (wb_req),
        .store       (store),
        .wb_ack      (wb_ack),
        .dma_wr      (dma_wr),
        .dma_row_sel (dma_row_sel)
    );

    for (genvar r = 0; r < `UB_ROWS; r++) begin : g_row
        ub_row_bank u_bank (
            .clk       (clk),
            .reset     (reset),
            .dma_wr    (dma_wr),
            .dma_sel   (dma_row_sel[r]),
            .row_store (store && acc_full[r]), // each row gated by its own full flag
            .row_in    (acc_rows[r]),
            .rd_col    (rd_col),
            .rd_data   (bank_data[r])
        );
    end

    ub_stream_out u_stream_out (
        .clk       (clk),
        .reset     (reset),
        .ext_start (ext_start),
        .bank_data (bank_data),
        .out_ready (out_ready),
        .rd_col    (rd_col),
        .out_beat  (out_beat),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

// ==== verif/tb_unified_buffer.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "ub_config.svh"

module tb_unified_buffer;

    import ub_pkg::*;

    localparam int WORDS      = `UB_ROWS * `UB_COLS;
    localparam int SEED       = 73802;
    localparam int N_WR       = 40;
    localparam int WR_MAX     = 4;              // drive, ack, drop, spare
    localparam int STREAM_MAX = WORDS * 4 + 8;  // ready is never low more than 3 cycles running
    localparam int RUN_MAX    = 16 + 6 * STREAM_MAX + (N_WR + 4) * WR_MAX + 16;
    localparam int TIMEOUT    = 4 * RUN_MAX;

    logic                clk;
    logic                reset;
    wb_req_t             wb_req;
    logic                wb_ack;
    logic                store;
    logic [`UB_ROWS-1:0] acc_full;
    act_row_t            acc_rows [`UB_ROWS];
    logic                ext_start;
    stream_beat_t        out_beat;
    logic                out_valid;
    logic                out_ready;

    ub_word_t     model [WORDS];  // reference memory
    stream_beat_t beats [$];
    string        test_name;
    int           test_errors;
    int           errors = 0;
    int           tests_run = 0;
    int           tests_failed = 0;
    int           cycles = 0;

    unified_buffer DUT (
        .clk       (clk),
        .reset     (reset),
        .wb_req    (wb_req),
        .wb_ack    (wb_ack),
        .store     (store),
        .acc_full  (acc_full),
        .acc_rows  (acc_rows),
        .ext_start (ext_start),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout: no result after %0d cycles, the DUT stopped responding", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_word(input ub_word_t exp, input ub_word_t act, input string name);
        if (act !== exp) begin
            $display("ERR %s: expected %h actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_beat(input stream_beat_t exp, input stream_beat_t act,
                              input string name);
        if (act !== exp) begin
            $display("ERR %s: expected data %h last %b actual data %h last %b",
                     name, exp.data, exp.last, act.data, act.last);
            test_errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s: %s", test_name, what);
        test_errors++;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test;
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, test_errors);
        end
        errors += test_errors;
    endtask

    // all tasks start and end 2 ns after a rising edge
    task automatic wait_ack(output int waits);
        waits = 0;
        do begin
            @(posedge clk);
            #2;
            waits++;
        end while (!wb_ack);
        wb_req = '0; // drop stb after ack
        @(posedge clk); // stb stays low for one cycle
        #2;
    endtask

    task automatic wb_transfer(input logic [`UB_ADDR_W-1:0] adr, input ub_word_t dat,
                               input logic write);
        int waits;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: write, adr: adr, dat: dat};
        wait_ack(waits);
        if (waits != 1) report_failure("ack did not come one cycle after the request");
        if (write) model[adr] = dat;
    endtask

    task automatic row_store(input logic [`UB_ROWS-1:0] mask, input int hold,
                             input logic addr_tag);
        for (int r = 0; r < `UB_ROWS; r++) begin
            for (int c = 0; c < `UB_COLS; c++) begin
                if (addr_tag) // low bits carry the word address
                    acc_rows[r][c] = ub_word_t'(($urandom << `UB_ADDR_W) | (r * `UB_COLS + c));
                else
                    acc_rows[r][c] = ub_word_t'($urandom);
            end
        end
        acc_full = mask;
        store    = 1'b1;
        repeat (hold) begin
            @(posedge clk);
            #2;
            if (wb_ack) report_failure("wb_ack rose while store was high");
        end
        store    = 1'b0;
        acc_full = '0;
        for (int r = 0; r < `UB_ROWS; r++) begin
            if (mask[r]) begin
                for (int c = 0; c < `UB_COLS; c++) model[r * `UB_COLS + c] = acc_rows[r][c];
            end
        end
    endtask

    task automatic stream_all(input logic poke_start);
        int           low_run;
        stream_beat_t exp;
        beats.delete();
        low_run   = 0;
        ext_start = 1'b1;
        @(posedge clk);
        #2;
        ext_start = 1'b0;
        if (!out_valid) report_failure("out_valid did not rise one cycle after ext_start");
        while (beats.size() < WORDS) begin
            ext_start = poke_start && ($urandom % 4 == 0); // stray starts while running
            out_ready = (low_run >= 3) || ($urandom % 4 != 0);
            low_run   = out_ready ? 0 : low_run + 1;
            @(negedge clk);
            if (out_valid && out_ready) beats.push_back(out_beat);
            @(posedge clk);
            #2;
        end
        ext_start = 1'b0;
        out_ready = 1'b0;
        if (out_valid) report_failure("out_valid still high after the last beat");
        @(posedge clk);
        #2;
        if (out_valid) report_failure("stream started again after the last beat");
        for (int k = 0; k < WORDS; k++) begin
            exp.data = model[k];
            exp.last = (k == WORDS - 1);
            check_beat(exp, beats[k], test_name);
        end
    endtask

    initial begin
        logic [`UB_ADDR_W-1:0] adr;
        logic [`UB_ADDR_W-1:0] prev_adr;
        logic [`UB_ROWS-1:0]   mask;
        logic [`UB_ROW_W-1:0]  row;
        ub_word_t              dat;
        int                    waits;

        void'($urandom(SEED));
        reset     = 1'b1;
        wb_req    = '0;
        store     = 1'b0;
        acc_full  = '0;
        ext_start = 1'b0;
        out_ready = 1'b0;
        for (int r = 0; r < `UB_ROWS; r++) acc_rows[r] = '0;
        for (int k = 0; k < WORDS; k++) model[k] = '0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;

        begin_test("reset_stream");
        if (wb_ack || out_valid) report_failure("handshake outputs high after reset");
        stream_all(1'b0);
        end_test();

        begin_test("wb_writes");
        prev_adr = '0;
        for (int i = 0; i < N_WR; i++) begin
            adr = (i % 4 == 3) ? prev_adr : `UB_ADDR_W'($urandom); // some repeats
            wb_transfer(adr, ub_word_t'($urandom), 1'b1);
            prev_adr = adr;
            if (i % 10 == 5) wb_transfer(`UB_ADDR_W'($urandom), ub_word_t'($urandom), 1'b0);
        end
        stream_all(1'b0);
        end_test();

        begin_test("row_store");
        mask = `UB_ROWS'($urandom);
        row_store(mask, 1, 1'b0);
        stream_all(1'b0);
        end_test();

        begin_test("store_defers_wb");
        row  = `UB_ROW_W'($urandom);
        mask = `UB_ROWS'($urandom) | (`UB_ROWS'(1) << row);
        adr  = {row, `UB_COL_W'($urandom)};
        dat  = ub_word_t'($urandom);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
        row_store(mask, 3, 1'b0);
        wait_ack(waits);
        if (waits != 1) report_failure("ack did not come one cycle after store dropped");
        model[adr] = dat; // dma word lands on top of the stored row
        stream_all(1'b0);
        check_word(dat, beats[adr].data, test_name);
        end_test();

        begin_test("backpressure");
        row_store('1, 1, 1'b1); // every word distinct
        stream_all(1'b0);
        end_test();

        begin_test("start_ignored");
        stream_all(1'b1);
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+verilog
verilog/ub_pkg.sv
verilog/ub_dma_port.sv
verilog/ub_row_bank.sv
verilog/ub_stream_out.sv
verilog/unified_buffer.sv
verif/tb_unified_buffer.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_unified_buffer
FILELIST  := tb.f

OBJDIR  := obj_dir
BIN     := $(OBJDIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# status follows the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf $(OBJDIR)
